// File: flist.f
src/noiseVideoPkg.sv
src/videoBeamIf.sv
src/videoTiming.sv
src/noiseSource.sv
src/videoOutStage.sv
src/activityLed.sv
src/noiseVideoTop.sv
dv/noiseVideoTb.sv

// File: Makefile
TOP := noiseVideoTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f flist.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dv/noiseVideoTb.sv
`timescale 1ns/1ns
`default_nettype none

module noiseVideoTb;

    // Geometry as set by the DUT defaults
    localparam int hActive     = 256;
    localparam int hSyncWidth  = 24;
    localparam int vActiveNtsc = 224;
    localparam int vTotalNtsc  = 262;
    localparam int vActivePal  = 256;
    localparam int vTotalPal   = 312;
    localparam int ledCntW     = 12;
    localparam int frameLimit  = 2000000;
    localparam int pulseLimit  = 200;
    localparam logic [15:0] noiseSeed = 16'hACE1;

    logic                      clk_sys;
    logic                      rstN;
    logic                      pal;
    logic                      scandouble;
    noiseVideoPkg::noiseColorT noiseColor = noiseVideoPkg::tintWhite;
    noiseVideoPkg::aspectT     aspect;
    logic                      cePixel;
    logic [7:0]                vgaR;
    logic [7:0]                vgaG;
    logic [7:0]                vgaB;
    logic                      vgaHs;
    logic                      vgaVs;
    logic                      vgaDe;
    logic [12:0]               videoArx;
    logic [12:0]               videoAry;
    logic                      ledUser;

    // Error tallies of the checker and the main sequence
    int checkErrors = 0;
    int seqErrors   = 0;
    int timeouts    = 0;

    // Mirrors kept by the checker
    logic                      primed        = 1'b0;
    logic [1:0]                rstHist       = 2'b00;
    logic [15:0]               refLfsr       = 16'hACE1;
    logic [ledCntW-1:0]        ledCnt        = '0;
    logic                      ledExp        = 1'b0;
    int                        ledCycles     = 0;
    int                        pixelsChecked = 0;
    noiseVideoPkg::noiseColorT colorPrev     = noiseVideoPkg::tintWhite;
    noiseVideoPkg::aspectT     aspectPrev    = noiseVideoPkg::aspectOriginal;

    noiseVideoTop #(
        .ledCntW (ledCntW)
    ) u_dut (
        .clk_sys    (clk_sys),
        .rstN       (rstN),
        .pal        (pal),
        .scandouble (scandouble),
        .noiseColor (noiseColor),
        .aspect     (aspect),
        .cePixel    (cePixel),
        .vgaR       (vgaR),
        .vgaG       (vgaG),
        .vgaB       (vgaB),
        .vgaHs      (vgaHs),
        .vgaVs      (vgaVs),
        .vgaDe      (vgaDe),
        .videoArx   (videoArx),
        .videoAry   (videoAry),
        .ledUser    (ledUser)
    );

    initial clk_sys = 1'b0;
    always #20 clk_sys = ~clk_sys;

    // ==================================================
    // Reference model
    // ==================================================

    // x^16 + x^14 + x^13 + x^11 + 1 with the new bit entering at the top
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic newBit;
        newBit = s[0] ^ s[2] ^ s[3] ^ s[5];
        return {newBit, s[15:1]};
    endfunction

    // Packed as R, G, B
    function automatic logic [23:0] tintRgb(input logic [7:0] y,
                                            input noiseVideoPkg::noiseColorT color);
        case (color)
            noiseVideoPkg::tintRed:   return {y, 8'h00, 8'h00};
            noiseVideoPkg::tintGreen: return {8'h00, y, 8'h00};
            noiseVideoPkg::tintBlue:  return {8'h00, 8'h00, y};
            default:                  return {y, y, y};
        endcase
    endfunction

    // Packed as x, y
    function automatic logic [25:0] aspectPair(input noiseVideoPkg::aspectT code);
        if (code == noiseVideoPkg::aspectOriginal) begin
            return {13'd4, 13'd3};
        end
        return {13'(code) - 13'd1, 13'd0};
    endfunction

    function automatic logic ledRule(input logic [ledCntW-1:0] cnt);
        logic [7:0] slowByte;
        logic [7:0] fastByte;
        slowByte = cnt[ledCntW-2 -: 8];
        fastByte = cnt[7:0];
        return cnt[ledCntW-1] ? (slowByte > fastByte) : (slowByte <= fastByte);
    endfunction

    // ==================================================
    // Checker of the outputs seen just before each rising edge
    // ==================================================

    always @(posedge clk_sys) begin
        logic [23:0] rgbExp;
        logic [25:0] arExp;
        if (primed) begin
            // Everything dark in reset and for one cycle after
            if (rstHist != 2'b11) begin
                assert (!vgaDe && !vgaHs && !vgaVs && !cePixel && {vgaR, vgaG, vgaB} == 24'h0)
                else begin
                    checkErrors++;
                    $display("Fail reset: vgaDe=%h vgaHs=%h vgaVs=%h cePixel=%h rgb=%h",
                             vgaDe, vgaHs, vgaVs, cePixel, {vgaR, vgaG, vgaB});
                end
            end
            if (cePixel && vgaDe) begin
                rgbExp = tintRgb(refLfsr[7:0], colorPrev);
                assert ({vgaR, vgaG, vgaB} == rgbExp)
                else begin
                    checkErrors++;
                    $display("Fail vgaR/vgaG/vgaB: got %h %h %h expected %h",
                             vgaR, vgaG, vgaB, rgbExp);
                end
                // One shift per visible pixel
                refLfsr = lfsrNext(refLfsr);
                pixelsChecked++;
            end
            arExp = aspectPair(aspectPrev);
            assert ({videoArx, videoAry} == arExp)
            else begin
                checkErrors++;
                $display("Fail videoArx/videoAry: got %h %h expected %h %h",
                         videoArx, videoAry, arExp[25:13], arExp[12:0]);
            end
            assert (ledUser == ledExp)
            else begin
                checkErrors++;
                $display("Fail ledUser: got %h expected %h", ledUser, ledExp);
            end
        end
        // Mirrors step with the DUT registers
        if (!rstN) begin
            refLfsr = noiseSeed;
        end
        ledExp    = rstN ? ledRule(ledCnt) : 1'b0;
        ledCnt    = rstN ? ledCnt + ledCntW'(1) : '0;
        ledCycles = rstN ? ledCycles + 1 : 0;
        rstHist   = {rstHist[0], rstN};
        colorPrev  = noiseColor;
        aspectPrev = aspect;
        primed     = 1'b1;
    end

    // New random tint at each hSync rise inside horizontal blanking
    initial begin
        logic hsLast;
        void'($urandom(56634));
        hsLast = 1'b0;
        forever begin
            @(negedge clk_sys);
            if (vgaHs === 1'b1 && !hsLast) begin
                noiseColor = noiseVideoPkg::noiseColorT'($urandom_range(3, 0));
            end
            hsLast = (vgaHs === 1'b1);
        end
    end

    // ==================================================
    // Sequence tasks sampling on the falling edge
    // ==================================================

    task automatic checkPixelRate(input int expGap);
        int gap;
        int timer;
        int pulses;
        gap    = 0;
        timer  = 0;
        pulses = 0;
        while (pulses < 12 && timer < pulseLimit) begin
            @(negedge clk_sys);
            timer++;
            gap++;
            if (cePixel) begin
                // First few gaps may straddle a rate change
                if (pulses >= 3) begin
                    assert (gap == expGap)
                    else begin
                        seqErrors++;
                        $display("Fail cePixel gap: got %h expected %h", gap, expGap);
                    end
                end
                pulses++;
                gap = 0;
            end
        end
        if (pulses < 12) begin
            timeouts++;
            $display("Timed out waiting for pixel strobes");
        end
    endtask

    task automatic waitVsyncRise();
        int   timer;
        logic last;
        logic found;
        timer = 0;
        found = 1'b0;
        last  = vgaVs;
        while (!found && timer < frameLimit) begin
            @(negedge clk_sys);
            timer++;
            found = vgaVs && !last;
            last  = vgaVs;
        end
        if (!found) begin
            timeouts++;
            $display("Timed out waiting for the start of vertical sync");
        end
    endtask

    // Counts from one vSync rise to the next
    task automatic measureFrame(input int expLines, input int expActive);
        int   timer;
        int   lines;
        int   activeLines;
        int   lineDe;
        int   hsPix;
        logic hsLast;
        logic vsLast;
        logic done;
        timer = 0;
        lines = 0;
        activeLines = 0;
        lineDe = 0;
        hsPix  = 0;
        hsLast = vgaHs;
        vsLast = vgaVs;
        done   = 1'b0;
        while (!done && timer < frameLimit) begin
            @(negedge clk_sys);
            timer++;
            if (vgaHs && !hsLast) begin
                lines++;
                if (lineDe != 0) begin
                    activeLines++;
                    assert (lineDe == hActive)
                    else begin
                        seqErrors++;
                        $display("Fail vgaDe pixels per line: got %h expected %h",
                                 lineDe, hActive);
                    end
                end
                lineDe = 0;
            end
            if (!vgaHs && hsLast) begin
                assert (hsPix == hSyncWidth)
                else begin
                    seqErrors++;
                    $display("Fail vgaHs width: got %h expected %h", hsPix, hSyncWidth);
                end
                hsPix = 0;
            end
            lineDe += int'(cePixel && vgaDe);
            hsPix  += int'(cePixel && vgaHs);
            done   = vgaVs && !vsLast;
            hsLast = vgaHs;
            vsLast = vgaVs;
        end
        if (!done) begin
            timeouts++;
            $display("Timed out measuring a frame");
        end
        assert (lines == expLines && activeLines == expActive)
        else begin
            seqErrors++;
            $display("Fail vgaHs lines: got %h expected %h, vgaDe lines: got %h expected %h",
                     lines, expLines, activeLines, expActive);
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        rstN       = 1'b0;
        pal        = 1'b0;
        scandouble = 1'b0;
        aspect     = noiseVideoPkg::aspectOriginal;
        repeat (5) @(negedge clk_sys);
        rstN = 1'b1;

        // NTSC at the normal pixel rate
        checkPixelRate(4);
        waitVsyncRise();
        measureFrame(vTotalNtsc, vActiveNtsc);

        // Walk all aspect codes while the checker follows
        for (int code = 0; code < 4; code++) begin
            @(negedge clk_sys);
            aspect = noiseVideoPkg::aspectT'(code);
            repeat (3) @(negedge clk_sys);
        end

        // PAL scandoubled with a mixed first frame after the switch
        pal        = 1'b1;
        scandouble = 1'b1;
        checkPixelRate(2);
        waitVsyncRise();
        waitVsyncRise();
        measureFrame(vTotalPal, vActivePal);

        assert (pixelsChecked > 0 && ledCycles >= 3 * (1 << ledCntW))
        else begin
            seqErrors++;
            $display("Too few visible pixels or LED cycles were checked");
        end

        $display("Check errors: %0d, sequence errors: %0d, timeouts: %0d",
                 checkErrors, seqErrors, timeouts);
        if (checkErrors == 0 && seqErrors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/noiseVideoTop.sv
`timescale 1ns/1ns
`default_nettype none

module noiseVideoTop #(
    parameter int hActive     = 256,
    parameter int hTotal      = 320,
    parameter int hSyncGap    = 8,
    parameter int hSyncWidth  = 24,
    parameter int vActiveNtsc = 224,
    parameter int vTotalNtsc  = 262,
    parameter int vActivePal  = 256,
    parameter int vTotalPal   = 312,
    parameter int vSyncGap    = 3,
    parameter int vSyncWidth  = 3,
    parameter int ledCntW     = 27
) (
    input  logic                             clk_sys,
    input  logic                             rstN,
    input  logic                             pal,
    input  logic                             scandouble,
    input  noiseVideoPkg::noiseColorT        noiseColor,
    input  noiseVideoPkg::aspectT            aspect,
    output logic                             cePixel,
    output noiseVideoPkg::lumaT              vgaR,
    output noiseVideoPkg::lumaT              vgaG,
    output noiseVideoPkg::lumaT              vgaB,
    output logic                             vgaHs,
    output logic                             vgaVs,
    output logic                             vgaDe,
    output logic [noiseVideoPkg::arW-1:0]    videoArx,
    output logic [noiseVideoPkg::arW-1:0]    videoAry,
    output logic                             ledUser
);

    // Beam position shared by the pixel pipeline
    videoBeamIf beam ();

    noiseVideoPkg::lumaT luma;

    // ==================================================
    // Video path
    // ==================================================

    videoTiming #(
        .hActive     (hActive),
        .hTotal      (hTotal),
        .hSyncGap    (hSyncGap),
        .hSyncWidth  (hSyncWidth),
        .vActiveNtsc (vActiveNtsc),
        .vTotalNtsc  (vTotalNtsc),
        .vActivePal  (vActivePal),
        .vTotalPal   (vTotalPal),
        .vSyncGap    (vSyncGap),
        .vSyncWidth  (vSyncWidth)
    ) uTiming (
        .clk_sys    (clk_sys),
        .rstN       (rstN),
        .pal        (pal),
        .scandouble (scandouble),
        .beam       (beam)
    );

    // Luma is valid while the beam is in the active area
    noiseSource uNoise (
        .clk_sys (clk_sys),
        .rstN    (rstN),
        .beam    (beam),
        .luma    (luma)
    );

    // One register stage to the output pins
    videoOutStage uOut (
        .clk_sys    (clk_sys),
        .rstN       (rstN),
        .beam       (beam),
        .luma       (luma),
        .noiseColor (noiseColor),
        .aspect     (aspect),
        .cePixel    (cePixel),
        .vgaHs      (vgaHs),
        .vgaVs      (vgaVs),
        .vgaDe      (vgaDe),
        .vgaR       (vgaR),
        .vgaG       (vgaG),
        .vgaB       (vgaB),
        .videoArx   (videoArx),
        .videoAry   (videoAry)
    );

    // Status LED, independent of the video path
    activityLed #(
        .ledCntW (ledCntW)
    ) uLed (
        .clk_sys (clk_sys),
        .rstN    (rstN),
        .ledUser (ledUser)
    );

endmodule

`default_nettype wire

// File: src/activityLed.sv
`timescale 1ns/1ns
`default_nettype none

module activityLed #(
    parameter int ledCntW = 27
) (
    input  logic clk_sys,
    input  logic rstN,
    output logic ledUser
);

    logic [ledCntW-1:0] cnt;
    logic [7:0]         upperByte;
    logic [7:0]         lowerByte;

    // Slow byte sets the duty, fast byte is the PWM ramp
    assign upperByte = cnt[ledCntW-2 -: 8];
    assign lowerByte = cnt[7:0];

    // ==================================================
    // Breathing PWM
    // ==================================================

    always_ff @(posedge clk_sys) begin
        if (!rstN) begin
            cnt     <= '0;
            ledUser <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;
            // Top bit flips the compare sense
            // so brightness ramps up then down
            if (cnt[ledCntW-1]) begin
                ledUser <= (upperByte > lowerByte);
            end else begin
                ledUser <= (upperByte <= lowerByte);
            end
        end
    end

endmodule

`default_nettype wire

// File: src/videoOutStage.sv
`timescale 1ns/1ns
`default_nettype none

module videoOutStage (
    input  logic                             clk_sys,
    input  logic                             rstN,
    videoBeamIf.sink                         beam,
    input  noiseVideoPkg::lumaT              luma,
    input  noiseVideoPkg::noiseColorT        noiseColor,
    input  noiseVideoPkg::aspectT            aspect,
    output logic                             cePixel,
    output logic                             vgaHs,
    output logic                             vgaVs,
    output logic                             vgaDe,
    output noiseVideoPkg::lumaT              vgaR,
    output noiseVideoPkg::lumaT              vgaG,
    output noiseVideoPkg::lumaT              vgaB,
    output logic [noiseVideoPkg::arW-1:0]    videoArx,
    output logic [noiseVideoPkg::arW-1:0]    videoAry
);

    // Native 4:3 ratio of the pattern
    localparam logic [noiseVideoPkg::arW-1:0] arOrigX = 4;
    localparam logic [noiseVideoPkg::arW-1:0] arOrigY = 3;

    logic                de;
    logic                useR;
    logic                useG;
    logic                useB;
    noiseVideoPkg::lumaT nextR;
    noiseVideoPkg::lumaT nextG;
    noiseVideoPkg::lumaT nextB;

    // ==================================================
    // Tint and data enable
    // ==================================================

    always_comb begin
        de   = !(beam.hBlank || beam.vBlank);
        // White drives all channels, other tints one each
        useR = (noiseColor == noiseVideoPkg::tintWhite) || (noiseColor == noiseVideoPkg::tintRed);
        useG = (noiseColor == noiseVideoPkg::tintWhite) || (noiseColor == noiseVideoPkg::tintGreen);
        useB = (noiseColor == noiseVideoPkg::tintWhite) || (noiseColor == noiseVideoPkg::tintBlue);
        // Black outside the active area
        nextR = (de && useR) ? luma : '0;
        nextG = (de && useG) ? luma : '0;
        nextB = (de && useB) ? luma : '0;
    end

    // All video outputs share one register stage to stay aligned
    always_ff @(posedge clk_sys) begin
        if (!rstN) begin
            cePixel <= 1'b0;
            vgaHs   <= 1'b0;
            vgaVs   <= 1'b0;
            vgaDe   <= 1'b0;
            vgaR    <= '0;
            vgaG    <= '0;
            vgaB    <= '0;
        end else begin
            cePixel <= beam.ce;
            vgaHs   <= beam.hSync;
            vgaVs   <= beam.vSync;
            vgaDe   <= de;
            vgaR    <= nextR;
            vgaG    <= nextG;
            vgaB    <= nextB;
        end
    end

    // Original mode reports 4:3
    // Other modes pass code minus one to select a scaler preset
    always_ff @(posedge clk_sys) begin
        if (aspect == noiseVideoPkg::aspectOriginal) begin
            videoArx <= arOrigX;
            videoAry <= arOrigY;
        end else begin
            videoArx <= noiseVideoPkg::arW'(aspect) - 1'b1;
            videoAry <= '0;
        end
    end

endmodule

`default_nettype wire

// File: src/noiseSource.sv
`timescale 1ns/1ns
`default_nettype none

module noiseSource (
    input  logic                clk_sys,
    input  logic                rstN,
    videoBeamIf.sink            beam,
    output noiseVideoPkg::lumaT luma
);

    logic [noiseVideoPkg::lfsrW-1:0] lfsr;
    logic                            feedback;
    logic                            advance;

    // Step only on visible pixels so the pattern is
    // independent of the pixel rate
    assign advance = beam.ce && !beam.hBlank && !beam.vBlank;

    // Taps 16, 14, 13, 11 counted from the output end
    assign feedback = lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5];

    // ==================================================
    // LFSR state
    // ==================================================

    // Fibonacci form, shifting towards bit 0
    always_ff @(posedge clk_sys) begin
        if (!rstN) begin
            lfsr <= noiseVideoPkg::lfsrSeed;
        end else if (advance) begin
            lfsr <= {feedback, lfsr[noiseVideoPkg::lfsrW-1:1]};
        end
    end

    // Low byte of the current state
    // The pixel sees the value before its own shift
    assign luma = lfsr[noiseVideoPkg::lumaW-1:0];

endmodule

`default_nettype wire

// File: src/videoTiming.sv
`timescale 1ns/1ns
`default_nettype none

module videoTiming #(
    parameter int hActive     = 256,
    parameter int hTotal      = 320,
    parameter int hSyncGap    = 8,
    parameter int hSyncWidth  = 24,
    parameter int vActiveNtsc = 224,
    parameter int vTotalNtsc  = 262,
    parameter int vActivePal  = 256,
    parameter int vTotalPal   = 312,
    parameter int vSyncGap    = 3,
    parameter int vSyncWidth  = 3
) (
    input  logic              clk_sys,
    input  logic              rstN,
    input  logic              pal,
    input  logic              scandouble,
    videoBeamIf.source        beam
);

    // Counter widths cover the longest line and the longer frame
    localparam int vMax  = (vTotalPal > vTotalNtsc) ? vTotalPal : vTotalNtsc;
    localparam int hCntW = $clog2(hTotal);
    localparam int vCntW = $clog2(vMax);

    // Horizontal thresholds in counter width
    localparam logic [hCntW-1:0] hLast      = hCntW'(hTotal - 1);
    localparam logic [hCntW-1:0] hActEnd    = hCntW'(hActive);
    localparam logic [hCntW-1:0] hSyncStart = hCntW'(hActive + hSyncGap);
    localparam logic [hCntW-1:0] hSyncEnd   = hCntW'(hActive + hSyncGap + hSyncWidth);

    logic [1:0]       ceDiv;
    logic [hCntW-1:0] hCount;
    logic [vCntW-1:0] vCount;

    // TV standard in force for the current frame
    logic             palLatched;

    logic [vCntW-1:0] vActEnd;
    logic [vCntW-1:0] vLast;
    logic [vCntW-1:0] vSyncStart;
    logic [vCntW-1:0] vSyncEnd;

    // ==================================================
    // Pixel enable
    // ==================================================

    // Divide by 4, or by 2 when scandoubled
    always_ff @(posedge clk_sys) begin
        if (!rstN) begin
            ceDiv   <= 2'd0;
            beam.ce <= 1'b0;
        end else begin
            ceDiv   <= ceDiv + 2'd1;
            beam.ce <= scandouble ? ceDiv[0] : (ceDiv == 2'd3);
        end
    end

    // ==================================================
    // Beam counters
    // ==================================================

    // Vertical thresholds follow the latched standard
    always_comb begin
        if (palLatched) begin
            vActEnd = vCntW'(vActivePal);
            vLast   = vCntW'(vTotalPal - 1);
        end else begin
            vActEnd = vCntW'(vActiveNtsc);
            vLast   = vCntW'(vTotalNtsc - 1);
        end
        vSyncStart = vActEnd + vCntW'(vSyncGap);
        vSyncEnd   = vSyncStart + vCntW'(vSyncWidth);
    end

    always_ff @(posedge clk_sys) begin
        if (!rstN) begin
            hCount     <= '0;
            vCount     <= '0;
            // Frame starts at reset, so take the standard here
            palLatched <= pal;
        end else if (beam.ce) begin
            if (hCount == hLast) begin
                hCount <= '0;
                if (vCount == vLast) begin
                    vCount     <= '0;
                    // Standard changes only on a frame boundary
                    palLatched <= pal;
                end else begin
                    vCount <= vCount + 1'b1;
                end
            end else begin
                hCount <= hCount + 1'b1;
            end
        end
    end

    // ==================================================
    // Blanking and sync
    // ==================================================

    // Levels settle one cycle after each counter step,
    // well before the next strobe
    always_ff @(posedge clk_sys) begin
        if (!rstN) begin
            beam.hBlank <= 1'b1;
            beam.vBlank <= 1'b1;
            beam.hSync  <= 1'b0;
            beam.vSync  <= 1'b0;
        end else begin
            beam.hBlank <= (hCount >= hActEnd);
            beam.vBlank <= (vCount >= vActEnd);
            beam.hSync  <= (hCount >= hSyncStart) && (hCount < hSyncEnd);
            beam.vSync  <= (vCount >= vSyncStart) && (vCount < vSyncEnd);
        end
    end

endmodule

`default_nettype wire

// File: src/videoBeamIf.sv
`timescale 1ns/1ns
`default_nettype none

// Beam timing shared by the pixel pipeline
interface videoBeamIf;

    // Pixel strobe, one clk_sys cycle wide
    logic ce;

    // Blanking levels, high outside the active area
    logic hBlank;
    logic vBlank;

    // Sync pulses, active high
    logic hSync;
    logic vSync;

    // Timing generator side
    modport source (
        output ce, hBlank, vBlank, hSync, vSync
    );

    // Consumers of the beam position
    modport sink (
        input ce, hBlank, vBlank, hSync, vSync
    );

endinterface

`default_nettype wire

// File: src/noiseVideoPkg.sv
`default_nettype none

package noiseVideoPkg;

    // ==================================================
    // Pixel data
    // ==================================================

    // One luma sample, also the width of each RGB channel
    localparam int lumaW = 8;

    typedef logic [lumaW-1:0] lumaT;

    // Tint applied to the noise luma
    typedef enum logic [1:0] {
        tintWhite = 2'd0,
        tintRed   = 2'd1,
        tintGreen = 2'd2,
        tintBlue  = 2'd3
    } noiseColorT;

    // ==================================================
    // Aspect ratio
    // ==================================================

    // Scaler aspect modes, codes as seen by the HDMI scaler
    typedef enum logic [1:0] {
        aspectOriginal = 2'd0,
        aspectFull     = 2'd1,
        aspectCustom1  = 2'd2,
        aspectCustom2  = 2'd3
    } aspectT;

    // Width of each ratio output towards the scaler
    localparam int arW = 13;

    // ==================================================
    // Noise LFSR
    // ==================================================

    localparam int lfsrW = 16;

    // Any nonzero value works, zero would lock the LFSR
    localparam logic [lfsrW-1:0] lfsrSeed = 16'hACE1;

endpackage

`default_nettype wire
